// File: hdl/radar_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, sample types and capture modes of the digitizer
// the default widths are what the top level uses unless overridden
// out_sample_t must be at least as wide as the adc
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef RADAR_PKG_SV
`define RADAR_PKG_SV

package radar_pkg;

   localparam int ADC_W = 12;   // lfrx adc sample width
   localparam int CNT_W = 32;   // counters, intervals, ages

   typedef logic [ADC_W-1:0] adc_t;         // one unsigned adc sample
   typedef logic [15:0]      out_sample_t;  // adc value, zero-extended
   typedef logic [CNT_W-1:0] count_t;       // counts, intervals, latency
   typedef logic [15:0]      rate_t;        // decimation rate

   // capture modes; anything but video runs continuously
   typedef enum logic [2:0] {
      MODE_VIDEO      = 3'd0,  // pulse-synced video, optionally negated
      MODE_RAW_VID    = 3'd1,
      MODE_RAW_TRG    = 3'd2,
      MODE_RAW_ARP    = 3'd3,
      MODE_RAW_ACP    = 3'd4,
      MODE_INTERLEAVE = 3'd5   // vid, trg, arp, acp round robin
   } mode_e;

endpackage

`endif

// File: hdl/pulse_detector.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// threshold pulse detector with hysteresis and dead time
// pulse is high for one cycle, one cycle after the input crosses
// thresh_excite while armed; re-arm needs the input at or below
// thresh_relax and latency cycles gone since the pulse
// thresh_relax is expected below thresh_excite
// age saturates, interval is in clk64 cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module pulse_detector #(
   parameter int ADC_W = radar_pkg::ADC_W,
   parameter int CNT_W = radar_pkg::CNT_W
) (
   input  logic             clk64,
   input  logic             rx_dsp_reset,
   input  logic             enable,
   input  logic [ADC_W-1:0] signal_in,
   input  logic [ADC_W-1:0] thresh_excite,
   input  logic [ADC_W-1:0] thresh_relax,
   input  logic [CNT_W-1:0] latency,        // min cycles from pulse to re-arm
   output logic             pulse,
   output logic [CNT_W-1:0] count,          // pulses since reset
   output logic [CNT_W-1:0] interval,       // cycles between last two pulses
   output logic [CNT_W-1:0] age             // cycles since last pulse
);

   logic armed;   // waiting for an excursion above excite
   logic fire;
   logic rearm;

   assign fire = armed && enable && (signal_in >= thresh_excite);

   // before the first pulse there is no dead time to honour, only the
   // relax level, so an input already high out of reset is not counted
   assign rearm = !armed && (signal_in <= thresh_relax) &&
                  ((age >= latency) || (count == '0));

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         armed    <= 1'b0;
         pulse    <= 1'b0;
         count    <= '0;
         interval <= '0;
         age      <= '0;
      end
      else
      begin
         pulse <= fire;
         if (fire)
         begin
            armed    <= 1'b0;               // dead time starts here
            count    <= count + 1'b1;
            interval <= age + 1'b1;         // age lags the pulse edge by one
            age      <= '0;
         end
         else
         begin
            if (rearm)
               armed <= 1'b1;
            if (age != '1)
               age <= age + 1'b1;           // hold at max, no wrap
         end
      end
   end

   // one edge per excursion, never a stretched pulse
   a_pulse_single: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      pulse |=> !pulse);

endmodule

// File: hdl/sample_clock_decim.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decimated sample strobe, one pulse every decim_rate cycles
// first pulse decim_rate cycles after start; decim_rate of 0 acts as
// 65536, and a rate of at least 2 keeps capture lengths exact
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sample_clock_decim (
   input  logic              clk64,
   input  logic              rx_dsp_reset,
   input  logic              active,       // capture running
   input  logic              start,        // restarts the divider
   input  radar_pkg::rate_t  decim_rate,
   output logic              decim_strobe
);

   radar_pkg::rate_t cnt;   // cycles left to next strobe

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
         cnt <= '0;
      else if (start)
         cnt <= decim_rate - 1'b1;
      else if (active)
         cnt <= (cnt == '0) ? decim_rate - 1'b1 : cnt - 1'b1;   // reload on strobe
   end

   assign decim_strobe = active && !start && (cnt == '0);

   // strobes belong to a capture already under way, never its first cycle
   a_strobe_in_capture: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      decim_strobe |-> active && $past(active));

endmodule

// File: hdl/capture_control.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decides when a capture starts and ends
// video mode waits for a trigger pulse, every other mode restarts as
// soon as it goes idle; triggers during a capture are dropped
// a capture ends after n_samples output strobes, n_samples >= 1
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module capture_control #(
   parameter int CNT_W = radar_pkg::CNT_W
) (
   input  logic              clk64,
   input  logic              rx_dsp_reset,
   input  logic              enable,
   input  radar_pkg::mode_e  mode,
   input  logic              trigger,         // pulse from trigger detector
   input  logic              sample_strobe,   // one delivered sample
   input  logic [CNT_W-1:0]  n_samples,       // samples per capture
   output logic              start,
   output logic              capture_active
);

   logic             continuous;
   logic [CNT_W-1:0] n_done;   // samples delivered this capture

   assign continuous = (mode != radar_pkg::MODE_VIDEO);

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         start          <= 1'b0;
         capture_active <= 1'b0;
         n_done         <= '0;
      end
      else
      begin
         start <= 1'b0;
         if (!capture_active && enable && (continuous || trigger))
         begin
            start          <= 1'b1;   // active rises in the same edge
            capture_active <= 1'b1;
            n_done         <= '0;
         end
         else if (capture_active && sample_strobe)
         begin
            if (n_done == n_samples - 1'b1)
            begin
               capture_active <= 1'b0;   // last sample of this capture
               n_done         <= '0;
            end
            else
               n_done <= n_done + 1'b1;
         end
      end
   end

   // captures never overlap
   a_start_when_idle: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      start |-> !$past(capture_active));

endmodule

// File: hdl/source_select.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// picks the sample source for the mode and registers the output
// sample_strobe follows decim_strobe by one cycle, data taken from the
// inputs of the decim_strobe cycle; ADC_W must not exceed 16
// interleave order restarts at video on every start
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module source_select #(
   parameter int ADC_W = radar_pkg::ADC_W
) (
   input  logic                   clk64,
   input  logic                   rx_dsp_reset,
   input  logic                   start,
   input  logic                   decim_strobe,
   input  radar_pkg::mode_e       mode,
   input  logic                   vid_negate,
   input  logic [ADC_W-1:0]       video,
   input  logic [ADC_W-1:0]       trigger_lvl,
   input  logic [ADC_W-1:0]       arp_lvl,
   input  logic [ADC_W-1:0]       acp_lvl,
   output radar_pkg::out_sample_t sample_data,
   output logic                   sample_strobe
);

   logic [1:0]       phase;   // interleave slot, sample index mod 4
   logic [ADC_W-1:0] sel;

   always_comb
   begin
      case (mode)
         radar_pkg::MODE_VIDEO:   sel = vid_negate ? {ADC_W{1'b1}} - video : video;
         radar_pkg::MODE_RAW_VID: sel = video;
         radar_pkg::MODE_RAW_TRG: sel = trigger_lvl;
         radar_pkg::MODE_RAW_ARP: sel = arp_lvl;
         radar_pkg::MODE_RAW_ACP: sel = acp_lvl;
         radar_pkg::MODE_INTERLEAVE:
            case (phase)
               2'd0:    sel = video;
               2'd1:    sel = trigger_lvl;
               2'd2:    sel = arp_lvl;
               default: sel = acp_lvl;
            endcase
         default: sel = '0;
      endcase
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         phase         <= 2'd0;
         sample_strobe <= 1'b0;
      end
      else
      begin
         sample_strobe <= decim_strobe;
         if (start)
            phase <= 2'd0;
         else if (decim_strobe)
            phase <= phase + 2'd1;   // wraps after acp
      end
   end

   always_ff @(posedge clk64)
   begin
      if (decim_strobe)
         sample_data <= radar_pkg::out_sample_t'(sel);   // zero-extend
   end

   a_mode_legal: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      mode <= radar_pkg::MODE_INTERLEAVE);

endmodule

// File: hdl/azimuth_tracker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// heading bookkeeping, acp count and acp age seen at each arp pulse
// outputs change the cycle after the arp pulse and hold until the next
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module azimuth_tracker #(
   parameter int CNT_W = radar_pkg::CNT_W
) (
   input  logic             clk64,
   input  logic             rx_dsp_reset,
   input  logic             arp_pulse,            // heading mark
   input  logic [CNT_W-1:0] acp_count,            // acps since reset
   input  logic [CNT_W-1:0] acp_age,              // cycles since last acp
   output logic [CNT_W-1:0] acp_count_last_arp,
   output logic [CNT_W-1:0] acp_age_last_arp
);

   // both values sampled in the arp cycle itself
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         acp_count_last_arp <= '0;
         acp_age_last_arp   <= '0;
      end
      else if (arp_pulse)
      begin
         acp_count_last_arp <= acp_count;
         acp_age_last_arp   <= acp_age;   // sub-acp heading offset
      end
   end

   // Per-sweep ACP bookkeeping would sit alongside these registers,
   // since it needs the same ARP qualification.

endmodule

// File: hdl/radar_digitizer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pulse-synchronised sample path of the marine radar digitizer
// adc inputs are fixed: video, trigger, arp (heading), acp (azimuth)
// all settings are static while enable is high; enable acts at once
// sample_strobe is a one-cycle valid with no back-pressure
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module radar_digitizer #(
   parameter int ADC_W = radar_pkg::ADC_W,
   parameter int CNT_W = radar_pkg::CNT_W
) (
   input  logic                   clk64,
   input  logic                   rx_dsp_reset,
   input  logic [ADC_W-1:0]       rx_video,
   input  logic [ADC_W-1:0]       rx_trigger,
   input  logic [ADC_W-1:0]       rx_arp,
   input  logic [ADC_W-1:0]       rx_acp,
   input  logic                   enable,
   input  radar_pkg::mode_e       mode,
   input  logic                   vid_negate,
   input  logic [ADC_W-1:0]       trig_thresh_excite,
   input  logic [ADC_W-1:0]       trig_thresh_relax,
   input  logic [CNT_W-1:0]       trig_latency,
   input  logic [ADC_W-1:0]       arp_thresh_excite,
   input  logic [ADC_W-1:0]       arp_thresh_relax,
   input  logic [CNT_W-1:0]       arp_latency,
   input  logic [ADC_W-1:0]       acp_thresh_excite,
   input  logic [ADC_W-1:0]       acp_thresh_relax,
   input  logic [CNT_W-1:0]       acp_latency,
   input  radar_pkg::rate_t       decim_rate,
   input  logic [CNT_W-1:0]       n_samples,
   output radar_pkg::out_sample_t sample_data,
   output logic                   sample_strobe,
   output logic                   capture_active,
   output logic [CNT_W-1:0]       n_trigs,
   output logic [CNT_W-1:0]       n_arps,
   output logic [CNT_W-1:0]       n_acps,
   output logic [CNT_W-1:0]       trig_interval,
   output logic [CNT_W-1:0]       acp_interval,
   output logic [CNT_W-1:0]       acp_count_last_arp,
   output logic [CNT_W-1:0]       acp_age_last_arp
);

   logic             trig_pulse, arp_pulse;
   logic [CNT_W-1:0] acp_age;        // cycles since last acp
   logic             cap_start;      // one cycle, opens a capture
   logic             decim_strobe;

   pulse_detector #(.ADC_W(ADC_W), .CNT_W(CNT_W)) trig_det (
      .clk64, .rx_dsp_reset, .enable, .signal_in(rx_trigger),
      .thresh_excite(trig_thresh_excite), .thresh_relax(trig_thresh_relax),
      .latency(trig_latency), .pulse(trig_pulse), .count(n_trigs),
      .interval(trig_interval), .age());

   pulse_detector #(.ADC_W(ADC_W), .CNT_W(CNT_W)) arp_det (
      .clk64, .rx_dsp_reset, .enable, .signal_in(rx_arp),
      .thresh_excite(arp_thresh_excite), .thresh_relax(arp_thresh_relax),
      .latency(arp_latency), .pulse(arp_pulse), .count(n_arps),
      .interval(), .age());

   pulse_detector #(.ADC_W(ADC_W), .CNT_W(CNT_W)) acp_det (
      .clk64, .rx_dsp_reset, .enable, .signal_in(rx_acp),
      .thresh_excite(acp_thresh_excite), .thresh_relax(acp_thresh_relax),
      .latency(acp_latency), .pulse(), .count(n_acps),
      .interval(acp_interval), .age(acp_age));

   capture_control #(.CNT_W(CNT_W)) capture_ctrl (
      .clk64, .rx_dsp_reset, .enable, .mode, .trigger(trig_pulse),
      .sample_strobe, .n_samples, .start(cap_start), .capture_active);

   sample_clock_decim clock_decim (
      .clk64, .rx_dsp_reset, .active(capture_active), .start(cap_start),
      .decim_rate, .decim_strobe);

   source_select #(.ADC_W(ADC_W)) src_sel (
      .clk64, .rx_dsp_reset, .start(cap_start), .decim_strobe, .mode, .vid_negate,
      .video(rx_video), .trigger_lvl(rx_trigger), .arp_lvl(rx_arp), .acp_lvl(rx_acp),
      .sample_data, .sample_strobe);

   azimuth_tracker #(.CNT_W(CNT_W)) az_track (
      .clk64, .rx_dsp_reset, .arp_pulse, .acp_count(n_acps), .acp_age,
      .acp_count_last_arp, .acp_age_last_arp);

endmodule

// File: testbench/tb_clock_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset, clk64 period 10
// rx_dsp_reset high for the first 2 rising edges
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_clock_gen (
   output logic clk64,
   output logic rx_dsp_reset
);

   initial
   begin
      clk64 = 1'b0;
      forever #5 clk64 = ~clk64;
   end

   initial
   begin
      rx_dsp_reset = 1'b1;
      repeat (2) @(posedge clk64);
      rx_dsp_reset <= 1'b0;   // released on the edge, like the other inputs
   end

endmodule

// File: testbench/tb_radar_digitizer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the radar digitizer, scenarios from radar_stim.txt
// counts are cumulative over the run, the file gives per-line deltas
// pulsed lines must not use raw modes, raw lines generate no pulses
// decim_rate >= 2 and pulse spacing >= 8 are assumed by the model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_radar_digitizer;

   localparam int TIMEOUT = 5000;   // cycles allowed for any single wait

   logic                   clk64, rx_dsp_reset, enable, vid_negate;
   logic [11:0]            rx_video, rx_trigger, rx_arp, rx_acp;
   logic [11:0]            trig_exc, trig_rel, arp_exc, arp_rel, acp_exc, acp_rel;
   radar_pkg::count_t      trig_lat, arp_lat, acp_lat, n_samples;
   radar_pkg::count_t      n_trigs, n_arps, n_acps, trig_interval, acp_interval;
   radar_pkg::count_t      acp_count_last_arp, acp_age_last_arp;
   radar_pkg::mode_e       mode;
   radar_pkg::rate_t       decim_rate;
   radar_pkg::out_sample_t sample_data;
   logic                   sample_strobe, capture_active;

   int    fd, rc, n_lines, seed;
   int    f [0:18];            // one parsed stimulus line
   string line;
   // settings of the running scenario, as the reference model sees them
   int    cur_mode, cur_neg, cur_rate, cur_nsamp, cur_exc, cur_rel;
   int    cur_vid, cur_trg, cur_arp, cur_acp;
   int    tot_trigs, tot_arps, tot_acps;   // expected running totals
   int    cyc, caps_scn, strobes, last_cyc;
   int    last_acp_cyc, last_arp_cyc;      // edges that raised the latest acp and arp
   bit    prev_active;

   tb_clock_gen clock_gen (.clk64, .rx_dsp_reset);

   radar_digitizer radar_digitizer_inst (
      .clk64, .rx_dsp_reset, .rx_video, .rx_trigger, .rx_arp, .rx_acp, .enable,
      .mode, .vid_negate,
      .trig_thresh_excite(trig_exc), .trig_thresh_relax(trig_rel), .trig_latency(trig_lat),
      .arp_thresh_excite(arp_exc), .arp_thresh_relax(arp_rel), .arp_latency(arp_lat),
      .acp_thresh_excite(acp_exc), .acp_thresh_relax(acp_rel), .acp_latency(acp_lat),
      .decim_rate, .n_samples, .sample_data, .sample_strobe, .capture_active,
      .n_trigs, .n_arps, .n_acps, .trig_interval, .acp_interval,
      .acp_count_last_arp, .acp_age_last_arp);

   task automatic check_count(input string name, input radar_pkg::count_t got,
                              input radar_pkg::count_t exp);
      if (got !== exp)
      begin
         $display("FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
         $display("Checks failed");
         $fatal(1, "count mismatch");
      end
   endtask

   task automatic check_sample(input string name, input radar_pkg::out_sample_t got,
                               input radar_pkg::out_sample_t exp);
      if (got !== exp)
      begin
         $display("FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
         $display("Checks failed");
         $fatal(1, "sample mismatch");
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s at t=%0t", why, $time);
      $display("Checks failed");
      $fatal(1, "run aborted");
   endtask

   // reference rule for sample idx of the current capture
   function automatic radar_pkg::out_sample_t expected_sample(input int idx);
      int v;
      case (cur_mode)
         0:       v = cur_neg ? 4095 - cur_vid : cur_vid;   // 12-bit full scale
         1:       v = cur_vid;
         2:       v = cur_trg;
         3:       v = cur_arp;
         4:       v = cur_acp;
         default:
            case (idx % 4)
               0:       v = cur_vid;
               1:       v = cur_trg;
               2:       v = cur_arp;
               default: v = cur_acp;
            endcase
      endcase
      return radar_pkg::out_sample_t'(v);
   endfunction

   task automatic set_level(input int ch, input int val);
      case (ch)
         0:       rx_trigger <= val[11:0];
         1:       rx_arp     <= val[11:0];
         default: rx_acp     <= val[11:0];
      endcase
   endtask

   // n pulses of one channel, rising edges spacing cycles apart
   task automatic make_pulses(input int ch, input int n, input int spacing);
      int hi, mid, held, k;
      hi   = (cur_exc + 500 > 4095) ? 4095 : cur_exc + 500;
      mid  = (cur_exc + cur_rel) / 2;   // between relax and excite, must not re-arm
      held = (ch == 0) ? cur_trg : (ch == 1) ? cur_arp : cur_acp;
      for (k = 0; k < n; k++)
      begin
         @(posedge clk64);
         if (ch == 2)
            last_acp_cyc = cyc;
         else if (ch == 1)
            last_arp_cyc = cyc;
         set_level(ch, hi);
         repeat (3) @(posedge clk64);
         set_level(ch, mid);
         repeat (2) @(posedge clk64);
         set_level(ch, hi);             // second excursion, no relax in between
         repeat (2) @(posedge clk64);
         set_level(ch, held);
         repeat (spacing - 8) @(posedge clk64);
      end
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      @(negedge clk64);
      while (capture_active !== 1'b0)
      begin
         if (n == TIMEOUT)
            abort_run("timeout waiting for the capture to end");
         n++;
         @(negedge clk64);
      end
   endtask

   task automatic wait_captures(input int want);
      int n;
      n = 0;
      @(negedge clk64);
      while (caps_scn < want)
      begin
         if (n == TIMEOUT)
            abort_run("timeout waiting for continuous captures");
         n++;
         @(negedge clk64);
      end
   endtask

   task automatic run_scenario();
      @(posedge clk64);
      enable <= 1'b0;
      wait_idle();
      @(posedge clk64);
      cur_mode   = f[0];
      cur_neg    = f[1];
      cur_rate   = f[2];
      cur_nsamp  = f[3];
      cur_exc    = f[4];
      cur_rel    = f[5];
      cur_vid    = f[7];
      cur_trg    = f[8];
      cur_arp    = f[9];
      cur_acp    = f[10];
      mode       <= radar_pkg::mode_e'(cur_mode);
      vid_negate <= cur_neg[0];
      decim_rate <= radar_pkg::rate_t'(cur_rate);
      n_samples  <= radar_pkg::count_t'(cur_nsamp);
      trig_exc   <= f[4][11:0];   // same thresholds on all
      arp_exc    <= f[4][11:0];
      acp_exc    <= f[4][11:0];
      trig_rel   <= f[5][11:0];
      arp_rel    <= f[5][11:0];
      acp_rel    <= f[5][11:0];
      trig_lat   <= f[6];
      arp_lat    <= f[6];
      acp_lat    <= f[6];
      rx_video   <= f[7][11:0];
      rx_trigger <= f[8][11:0];
      rx_arp     <= f[9][11:0];
      rx_acp     <= f[10][11:0];
      repeat ($urandom_range(3, 12)) @(posedge clk64);       // idle gap
      caps_scn = 0;
      enable <= 1'b1;
      if (cur_mode == 0)
      begin
         make_pulses(0, f[11], f[14]);   // triggers
         make_pulses(2, f[13], f[14]);   // acps before arps, for the latch
         make_pulses(1, f[12], f[14]);
         wait_idle();
         repeat (3) @(negedge clk64);
         check_count("captures", caps_scn, f[18]);
      end
      else
         wait_captures(f[18]);
      tot_trigs += f[15];
      tot_arps  += f[16];
      tot_acps  += f[17];
      @(negedge clk64);
      check_count("n_trigs", n_trigs, tot_trigs);
      check_count("n_arps", n_arps, tot_arps);
      check_count("n_acps", n_acps, tot_acps);
      if (f[11] >= 2)
         check_count("trig_interval", trig_interval, f[14]);
      if (f[13] >= 2)
         check_count("acp_interval", acp_interval, f[14]);
      if (f[12] > 0)
      begin
         check_count("acp_count_last_arp", acp_count_last_arp, tot_acps);
         // each pulse lags its input edge by one, so the age is the edge distance
         if (last_acp_cyc >= 0)
            check_count("acp_age_last_arp", acp_age_last_arp,
                        radar_pkg::count_t'(last_arp_cyc - last_acp_cyc));
      end
   endtask

   always @(posedge clk64)
      cyc <= cyc + 1;

   // capture monitor, samples outputs mid-cycle
   always @(negedge clk64)
   begin
      if (capture_active === 1'b1 && !prev_active)
      begin
         caps_scn++;
         strobes  = 0;
         last_cyc = cyc + 1;   // first strobe decim_rate+1 cycles after start
      end
      if (sample_strobe === 1'b1)
      begin
         check_count("sample gap", radar_pkg::count_t'(cyc - last_cyc), cur_rate);
         check_sample("sample_data", sample_data, expected_sample(strobes));
         strobes++;
         last_cyc = cyc;
      end
      if (capture_active === 1'b0 && prev_active)
         check_count("samples per capture", strobes, cur_nsamp);
      prev_active = (capture_active === 1'b1);
   end

   initial
   begin
      int n;
      seed = $urandom(81);   // seeds the generator once
      cyc          = 0;
      caps_scn     = 0;
      strobes      = 0;
      last_cyc     = 0;
      prev_active  = 1'b0;
      last_acp_cyc = -1;
      last_arp_cyc = -1;
      tot_trigs    = 0;
      tot_arps     = 0;
      tot_acps     = 0;
      n_lines      = 0;
      enable     <= 1'b0;
      mode       <= radar_pkg::MODE_VIDEO;
      vid_negate <= 1'b0;
      rx_video   <= '0;
      rx_trigger <= '0;
      rx_arp     <= '0;
      rx_acp     <= '0;
      trig_exc   <= 12'd2000;
      arp_exc    <= 12'd2000;
      acp_exc    <= 12'd2000;
      trig_rel   <= 12'd1000;
      arp_rel    <= 12'd1000;
      acp_rel    <= 12'd1000;
      trig_lat   <= '0;
      arp_lat    <= '0;
      acp_lat    <= '0;
      decim_rate <= 16'd2;
      n_samples  <= 1;
      n = 0;
      @(negedge clk64);
      while (rx_dsp_reset !== 1'b0)
      begin
         if (n == TIMEOUT)
            abort_run("timeout waiting for reset release");
         n++;
         @(negedge clk64);
      end
      fd = $fopen("testbench/radar_stim.txt", "r");
      if (fd == 0)
         abort_run("cannot open the stimulus file");
      while (!$feof(fd))
      begin
         rc = $fgets(line, fd);
         if (rc > 1 && line.getc(0) != "#")
         begin
            rc = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                         f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                         f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
            if (rc != 19)
               abort_run("malformed line in the stimulus file");
            run_scenario();
            n_lines++;
         end
      end
      $fclose(fd);
      if (n_lines == 0)
         abort_run("no scenarios in the stimulus file");
      else
      begin
         $display("All checks passed");
         $finish;
      end
   end

endmodule

// File: testbench/radar_stim.txt
# mode neg rate nsamp excite relax latency | video trig arp acp levels
# n_trig n_arp n_acp spacing | expected trig arp acp count deltas, captures
0 0 3 5 2000 1000 10 1234 300 450 700 3 0 0 40 3 0 0 3
0 1 4 25 2000 1000 10 1234 300 450 700 3 0 0 40 3 0 0 1
0 1 2 6 2000 1000 10 100 300 450 700 2 0 0 60 2 0 0 2
0 0 2 4 2000 1000 10 2047 300 450 700 0 0 5 30 0 0 5 0
0 0 2 4 2000 1000 10 2047 300 450 700 0 1 0 30 0 1 0 0
0 0 2 3 2000 1000 12 777 300 450 700 0 3 4 36 0 3 4 0
1 0 2 6 2000 1000 10 2500 300 450 700 0 0 0 40 0 0 0 2
1 1 3 4 2000 1000 10 3000 300 450 700 0 0 0 40 0 0 0 2
2 0 2 5 2000 1000 10 2500 311 450 700 0 0 0 40 0 0 0 2
3 0 4 3 2000 1000 10 2500 300 452 700 0 0 0 40 0 0 0 2
4 0 2 7 2000 1000 10 2500 300 450 701 0 0 0 40 0 0 0 2
5 0 3 9 2000 1000 10 4000 123 456 789 0 0 0 40 0 0 0 3
5 1 2 4 2000 1000 10 15 600 700 800 0 0 0 40 0 0 0 2
0 0 5 2 2000 1000 10 42 300 450 700 4 0 0 50 4 0 0 4

// File: flist.f
hdl/radar_pkg.sv
hdl/pulse_detector.sv
hdl/sample_clock_decim.sv
hdl/capture_control.sv
hdl/source_select.sv
hdl/azimuth_tracker.sv
hdl/radar_digitizer.sv
testbench/tb_clock_gen.sv
testbench/tb_radar_digitizer.sv

// File: Bender.yml
package:
  name: radar_digitizer

sources:
  - hdl/radar_pkg.sv
  - hdl/pulse_detector.sv
  - hdl/sample_clock_decim.sv
  - hdl/capture_control.sv
  - hdl/source_select.sv
  - hdl/azimuth_tracker.sv
  - hdl/radar_digitizer.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_radar_digitizer.sv
